//--- cp0If.sv
//**************************************************
// cp0 internal bus
// forwarded register views from the register file
// and trap / eret commits from the control FSM
//**************************************************

interface cp0If;

    import cp0Pkg::*;

    // views incl. any apb write in its access phase
    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;

    // commit strobes, applied at the next edge
    logic        trapEn;
    logic        eretEn;
    excCode_t    trapCode;
    logic [31:0] trapPc;

    // register side: drives views, takes commits
    modport regs (
        output status, cause, epc,
        input  trapEn, eretEn, trapCode, trapPc
    );

    // interrupt check only needs status and cause
    modport detect (
        input status, cause
    );

    // FSM issues commits, reads epc for eret target
    modport ctrl (
        output trapEn, eretEn, trapCode, trapPc,
        input  epc
    );

endinterface

//--- cp0Pkg.sv
//**************************************************
// coprocessor-0 shared definitions
// register indices, field positions, write masks,
// exception codes and control enums
//**************************************************

package cp0Pkg;

    // cp0 register number as seen on the apb address
    typedef logic [4:0] regIdx_t;

    localparam regIdx_t REG_COUNT   = 5'd9;
    localparam regIdx_t REG_COMPARE = 5'd11;
    localparam regIdx_t REG_STATUS  = 5'd12;
    localparam regIdx_t REG_CAUSE   = 5'd13;
    localparam regIdx_t REG_EPC     = 5'd14;

    // flags gathered by decode and execute
    typedef struct packed {
        logic reservedInstr;
        logic syscall;
        logic brk;
        logic overflow;
        logic wrBadAddr;
        logic rdBadAddr;
        logic eret;
    } exceptFlags_t;

    // mips ExcCode values
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } excCode_t;

    typedef enum logic [1:0] {NPC_NONE, NPC_EXCEPT, NPC_ERET} npcSel_t;

    typedef enum logic {IDLE, SETTLE} ctrlState_t;

    //**************************************************
    // field positions
    //**************************************************
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;

    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_IP_HI  = 15;
    // software bits IP1..IP0, hardware lines IP6..IP2
    localparam int CAUSE_SW_LO  = 8;
    localparam int CAUSE_SW_HI  = 9;
    localparam int CAUSE_HW_LO  = 10;
    localparam int CAUSE_HW_HI  = 14;
    // timer interrupt sits on IP7
    localparam int CAUSE_TI     = 15;

    // bits software may write
    localparam logic [31:0] STATUS_WR_MASK = 32'h0000_FF03;
    localparam logic [31:0] CAUSE_WR_MASK  = 32'h0000_0300;

endpackage

//--- cp0Regs.sv
//**************************************************
// cp0 register file with apb slave
// holds Status, Cause and EPC, routes Count and
// Compare to the timer, forwards access-phase
// writes to the exception logic
//**************************************************

module cp0Regs (
    input  logic              clk,
    input  logic              rst_i,
    // apb slave
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  cp0Pkg::regIdx_t   paddr_i,
    input  logic [31:0]       pwdata_i,
    output logic [31:0]       prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    // views and commits
    cp0If.regs                cp,
    // timer side
    output logic              countWr_o,
    output logic              compareWr_o,
    output logic [31:0]       wrData_o,
    input  logic [31:0]       count_i,
    input  logic [31:0]       compare_i,
    input  logic              timerIrq_i,
    // external interrupt lines IP6..IP2
    input  logic [4:0]        hwInt_i
);

    import cp0Pkg::*;

    logic        access;
    logic        mapped;
    logic        wrStatus;
    logic        wrCause;
    logic        wrEpc;
    logic [31:0] statusQ;
    logic [31:0] epcQ;
    excCode_t    excCodeQ;
    logic [1:0]  swIpQ;
    logic [31:0] causeRd;

    //**************************************************
    // apb decode
    //**************************************************
    // zero wait states, access phase is the only one that counts
    assign access   = psel_i && penable_i;
    assign mapped   = (paddr_i == REG_COUNT) || (paddr_i == REG_COMPARE) ||
                      (paddr_i == REG_STATUS) || (paddr_i == REG_CAUSE) ||
                      (paddr_i == REG_EPC);
    assign wrStatus = access && pwrite_i && (paddr_i == REG_STATUS);
    assign wrCause  = access && pwrite_i && (paddr_i == REG_CAUSE);
    assign wrEpc    = access && pwrite_i && (paddr_i == REG_EPC);

    assign pready_o  = 1'b1;
    assign pslverr_o = access && !mapped;

    // count and compare live in the timer
    assign countWr_o   = access && pwrite_i && (paddr_i == REG_COUNT);
    assign compareWr_o = access && pwrite_i && (paddr_i == REG_COMPARE);
    assign wrData_o    = pwdata_i;

    // stored cause, interrupt bits are live
    always_comb begin
        causeRd                            = '0;
        causeRd[CAUSE_TI]                  = timerIrq_i;
        causeRd[CAUSE_HW_HI:CAUSE_HW_LO]   = hwInt_i;
        causeRd[CAUSE_SW_HI:CAUSE_SW_LO]   = swIpQ;
        causeRd[CAUSE_EXC_HI:CAUSE_EXC_LO] = excCodeQ;
    end

    always_comb begin
        case (paddr_i)
            REG_COUNT:   prdata_o = count_i;
            REG_COMPARE: prdata_o = compare_i;
            REG_STATUS:  prdata_o = statusQ;
            REG_CAUSE:   prdata_o = causeRd;
            REG_EPC:     prdata_o = epcQ;
            default:     prdata_o = '0;
        endcase
    end

    //**************************************************
    // forwarded views
    //**************************************************
    // a write in flight overrides only the writable bits
    assign cp.status = wrStatus ? (pwdata_i & STATUS_WR_MASK) : statusQ;
    assign cp.cause  = wrCause ? ((causeRd & ~CAUSE_WR_MASK) | (pwdata_i & CAUSE_WR_MASK))
                               : causeRd;
    assign cp.epc    = wrEpc ? pwdata_i : epcQ;

    //**************************************************
    // register update
    //**************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            statusQ  <= '0;
            epcQ     <= '0;
            excCodeQ <= EXC_INT;
            swIpQ    <= '0;
        end else begin
            // software writes first
            if (wrStatus) begin
                statusQ <= pwdata_i & STATUS_WR_MASK;
            end
            if (wrCause) begin
                swIpQ <= pwdata_i[CAUSE_SW_HI:CAUSE_SW_LO];
            end
            if (wrEpc) begin
                epcQ <= pwdata_i;
            end
            // commits last so EXL, code and epc win
            if (cp.trapEn) begin
                statusQ[STATUS_EXL] <= 1'b1;
                excCodeQ            <= cp.trapCode;
                epcQ                <= cp.trapPc;
            end
            if (cp.eretEn) begin
                statusQ[STATUS_EXL] <= 1'b0;
            end
        end
    end

endmodule

//--- cp0Timer.sv
//**************************************************
// Count / Compare timer
// Count steps once every TICK_DIV cycles, a match
// sets a sticky timer interrupt flag
//**************************************************

module cp0Timer #(
    parameter int TICK_DIV = 2
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        countWr_i,
    input  logic        compareWr_i,
    input  logic [31:0] wrData_i,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timerIrq_o
);

    // keep at least one bit when TICK_DIV is 1
    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] divCnt;
    logic             tick;
    logic [31:0]      countNext;

    assign tick      = (divCnt == DIV_W'(TICK_DIV - 1));
    assign countNext = count_o + 32'd1;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            divCnt     <= '0;
            count_o    <= '0;
            compare_o  <= '0;
            timerIrq_o <= 1'b0;
        end else begin
            // prescaler
            divCnt <= tick ? '0 : divCnt + 1'b1;
            // software reload beats the advance
            if (countWr_i) begin
                count_o <= wrData_i;
            end else if (tick) begin
                count_o <= countNext;
            end
            // compare write acknowledges the interrupt
            if (compareWr_i) begin
                compare_o  <= wrData_i;
                timerIrq_o <= 1'b0;
            end else if (tick && !countWr_i && (countNext == compare_o)) begin
                timerIrq_o <= 1'b1;
            end
        end
    end

endmodule

//--- cp0Top.sv
//**************************************************
// exception and cp0 unit, memory stage view
// ties register file, timer, detection and the
// control FSM together
//**************************************************

module cp0Top #(
    parameter logic [31:0] EXC_VECTOR = 32'hBFC00380,
    parameter int          TICK_DIV   = 2
) (
    input  logic                        clk,
    input  logic                        rst_i,
    // apb slave
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  cp0Pkg::regIdx_t             paddr_i,
    input  logic                 [31:0] pwdata_i,
    output logic                 [31:0] prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    // interrupts and memory-stage instruction
    input  logic                  [4:0] hwInt_i,
    input  logic                        memValid_i,
    input  logic                 [31:0] memPc_i,
    input  cp0Pkg::exceptFlags_t        memFlags_i,
    input  logic                        memRegWr_i,
    // pipeline control
    output logic                        regWr_o,
    output logic                        flush_o,
    output cp0Pkg::npcSel_t             npcSel_o,
    output logic                 [31:0] npc_o,
    output cp0Pkg::excCode_t            excCode_o
);

    import cp0Pkg::*;

    cp0If cpBus ();

    // timer link
    logic        countWr;
    logic        compareWr;
    logic [31:0] wrData;
    logic [31:0] count;
    logic [31:0] compare;
    logic        timerIrq;
    // detect to control
    logic        excValid;
    logic        isEret;

    cp0Regs cp0Regs_inst (
        .clk(clk), .rst_i(rst_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .cp(cpBus.regs),
        .countWr_o(countWr), .compareWr_o(compareWr), .wrData_o(wrData),
        .count_i(count), .compare_i(compare), .timerIrq_i(timerIrq),
        .hwInt_i(hwInt_i)
    );

    cp0Timer #(.TICK_DIV(TICK_DIV)) cp0Timer_inst (
        .clk(clk), .rst_i(rst_i),
        .countWr_i(countWr), .compareWr_i(compareWr), .wrData_i(wrData),
        .count_o(count), .compare_o(compare), .timerIrq_o(timerIrq)
    );

    exceptDetect exceptDetect_inst (
        .memPc_i(memPc_i), .memFlags_i(memFlags_i), .cp(cpBus.detect),
        .excValid_o(excValid), .isEret_o(isEret), .excCode_o(excCode_o)
    );

    exceptCtrl #(.EXC_VECTOR(EXC_VECTOR)) exceptCtrl_inst (
        .clk(clk), .rst_i(rst_i),
        .memValid_i(memValid_i), .memPc_i(memPc_i), .memRegWr_i(memRegWr_i),
        .excValid_i(excValid), .isEret_i(isEret), .excCode_i(excCode_o),
        .cp(cpBus.ctrl),
        .regWr_o(regWr_o), .flush_o(flush_o), .npcSel_o(npcSel_o), .npc_o(npc_o)
    );

endmodule

//--- exceptCtrl.sv
//**************************************************
// exception control FSM
// kills the register write, flushes the pipe,
// picks the redirect and commits traps / erets
//**************************************************

module exceptCtrl #(
    parameter logic [31:0] EXC_VECTOR = 32'hBFC00380
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    memValid_i,
    input  logic             [31:0] memPc_i,
    input  logic                    memRegWr_i,
    input  logic                    excValid_i,
    input  logic                    isEret_i,
    input  cp0Pkg::excCode_t        excCode_i,
    cp0If.ctrl                      cp,
    output logic                    regWr_o,
    output logic                    flush_o,
    output cp0Pkg::npcSel_t         npcSel_o,
    output logic             [31:0] npc_o
);

    import cp0Pkg::*;

    ctrlState_t state;
    ctrlState_t stateNext;
    logic       take;

    // only a valid instruction seen in IDLE can redirect
    assign take = (state == IDLE) && memValid_i && (excValid_i || isEret_i);

    //**************************************************
    // outputs and commits
    //**************************************************
    always_comb begin
        regWr_o     = memRegWr_i;
        flush_o     = 1'b0;
        npcSel_o    = NPC_NONE;
        npc_o       = '0;
        cp.trapEn   = 1'b0;
        cp.eretEn   = 1'b0;
        cp.trapCode = excCode_i;
        cp.trapPc   = memPc_i;
        // SETTLE always falls back to IDLE
        stateNext   = IDLE;
        if (take) begin
            regWr_o   = 1'b0;
            flush_o   = 1'b1;
            stateNext = SETTLE;
            if (excValid_i) begin
                npcSel_o  = NPC_EXCEPT;
                npc_o     = EXC_VECTOR;
                cp.trapEn = 1'b1;
            end else begin
                // eret target, forwarded epc
                npcSel_o  = NPC_ERET;
                npc_o     = cp.epc;
                cp.eretEn = 1'b1;
            end
        end
    end

    //**************************************************
    // state register
    //**************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

endmodule

//--- exceptDetect.sv
//**************************************************
// exception detection
// merges stage flags, fetch alignment and pending
// interrupts into one prioritized exception code
//**************************************************

module exceptDetect (
    input  logic                  [31:0] memPc_i,
    input  cp0Pkg::exceptFlags_t         memFlags_i,
    cp0If.detect                         cp,
    output logic                         excValid_o,
    output logic                         isEret_o,
    output cp0Pkg::excCode_t             excCode_o
);

    import cp0Pkg::*;

    logic [7:0] ipMasked;
    logic       intPending;
    logic       pcMisaligned;

    //**************************************************
    // interrupt check
    //**************************************************
    // pending lines that software left unmasked
    assign ipMasked = cp.cause[CAUSE_IP_HI:CAUSE_IP_LO] &
                      cp.status[STATUS_IM_HI:STATUS_IM_LO];

    // blocked at exception level or with IE clear
    assign intPending = (|ipMasked) && !cp.status[STATUS_EXL] && cp.status[STATUS_IE];

    // fetch address error, word aligned only
    assign pcMisaligned = (memPc_i[1:0] != 2'b00);

    //**************************************************
    // priority select
    //**************************************************
    always_comb begin
        excValid_o = 1'b1;
        isEret_o   = 1'b0;
        excCode_o  = EXC_INT;
        if (intPending) begin
            excCode_o = EXC_INT;
        end else if (pcMisaligned) begin
            // bad fetch reports as a load error
            excCode_o = EXC_ADEL;
        end else if (memFlags_i.reservedInstr) begin
            excCode_o = EXC_RI;
        end else if (memFlags_i.syscall) begin
            excCode_o = EXC_SYS;
        end else if (memFlags_i.brk) begin
            excCode_o = EXC_BP;
        end else if (memFlags_i.overflow) begin
            excCode_o = EXC_OV;
        end else if (memFlags_i.wrBadAddr) begin
            // store address error
            excCode_o = EXC_ADES;
        end else if (memFlags_i.rdBadAddr) begin
            // load address error
            excCode_o = EXC_ADEL;
        end else if (memFlags_i.eret) begin
            // eret is not a trap, no code
            excValid_o = 1'b0;
            isEret_o   = 1'b1;
        end else begin
            excValid_o = 1'b0;
        end
    end

endmodule

//--- files.f
+incdir+.
cp0Pkg.sv
cp0If.sv
cp0Regs.sv
cp0Timer.sv
exceptDetect.sv
exceptCtrl.sv
cp0Top.sv
tbCp0Top.sv

//--- run.sh
#!/bin/sh
# build and run the cp0 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tbCp0Top -f files.f -Mdir obj_dir -o simCp0
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simCp0)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

//--- tbCp0Tasks.svh
//**************************************************
// directed tests for the cp0 testbench
// apb access, instruction issue, checks
//**************************************************

// one value against its expectation
task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
        errCount++;
        $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
endtask

// reference priority, interrupts assumed off
function automatic excCode_t expectedCode(input logic [31:0] pc, input exceptFlags_t f);
    if (pc[1:0] != 2'b00) return EXC_ADEL;
    if (f.reservedInstr) return EXC_RI;
    if (f.syscall) return EXC_SYS;
    if (f.brk) return EXC_BP;
    if (f.overflow) return EXC_OV;
    if (f.wrBadAddr) return EXC_ADES;
    if (f.rdBadAddr) return EXC_ADEL;
    return EXC_INT;
endfunction

//**************************************************
// apb and instruction drivers
//**************************************************
task automatic apbSetup(input regIdx_t idx, input logic wr, input logic [31:0] data);
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= idx;
    pwdata_i  <= data;
endtask

task automatic apbIdle;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
endtask

task automatic apbWrite(input regIdx_t idx, input logic [31:0] data);
    apbSetup(idx, 1'b1, data);
    @(posedge clk);
    penable_i <= 1'b1;
    // write lands on this edge
    @(posedge clk);
    apbIdle();
endtask

task automatic apbRead(input regIdx_t idx, output logic [31:0] data, output logic err);
    apbSetup(idx, 1'b0, 32'd0);
    @(posedge clk);
    penable_i <= 1'b1;
    // sample mid access phase
    @(negedge clk);
    data = prdata_o;
    err  = pslverr_o;
    checkEq("pready_o", 32'd1, 32'(pready_o));
    @(posedge clk);
    apbIdle();
endtask

task automatic driveInstr(input logic [31:0] pc, input exceptFlags_t flags, input logic wr);
    memValid_i <= 1'b1;
    memPc_i    <= pc;
    memFlags_i <= flags;
    memRegWr_i <= wr;
endtask

task automatic clearInstr;
    memValid_i <= 1'b0;
    memFlags_i <= '0;
    memRegWr_i <= 1'b0;
endtask

// output checks, called at the falling edge
task automatic expectTrap(input excCode_t code);
    checkEq("excCode_o", 32'(code), 32'(excCode_o));
    checkEq("flush_o", 32'd1, 32'(flush_o));
    checkEq("regWr_o", 32'd0, 32'(regWr_o));
    checkEq("npcSel_o", 32'(NPC_EXCEPT), 32'(npcSel_o));
    checkEq("npc_o", EXC_VECTOR, npc_o);
endtask

task automatic expectEret(input logic [31:0] target);
    checkEq("flush_o", 32'd1, 32'(flush_o));
    checkEq("regWr_o", 32'd0, 32'(regWr_o));
    checkEq("npcSel_o", 32'(NPC_ERET), 32'(npcSel_o));
    checkEq("npc_o", target, npc_o);
endtask

task automatic expectPass(input logic wr);
    checkEq("flush_o", 32'd0, 32'(flush_o));
    checkEq("regWr_o", 32'(wr), 32'(regWr_o));
    checkEq("npcSel_o", 32'(NPC_NONE), 32'(npcSel_o));
endtask

//**************************************************
// directed tests
//**************************************************
task automatic testRegAccess;
    logic [31:0] rd;
    logic        err;
    // reset state, count already runs
    apbRead(REG_COMPARE, rd, err);
    checkEq("Compare", 32'd0, rd);
    apbRead(REG_STATUS, rd, err);
    checkEq("Status", 32'd0, rd);
    apbRead(REG_CAUSE, rd, err);
    checkEq("Cause", 32'd0, rd);
    apbRead(REG_EPC, rd, err);
    checkEq("EPC", 32'd0, rd);
    checkEq("pslverr_o", 32'd0, 32'(err));
    // only IM, EXL and IE stick
    apbWrite(REG_STATUS, 32'hFFFF_FFFF);
    apbRead(REG_STATUS, rd, err);
    checkEq("Status", 32'h0000_FF03, rd);
    apbWrite(REG_STATUS, 32'd0);
    // only the two software lines stick
    apbWrite(REG_CAUSE, 32'hFFFF_FFFF);
    apbRead(REG_CAUSE, rd, err);
    checkEq("Cause", 32'h0000_0300, rd);
    apbWrite(REG_CAUSE, 32'd0);
    apbWrite(REG_EPC, 32'h8000_1234);
    apbRead(REG_EPC, rd, err);
    checkEq("EPC", 32'h8000_1234, rd);
    // far ahead so no match during the run
    apbWrite(REG_COMPARE, 32'h0001_0000);
    apbRead(REG_COMPARE, rd, err);
    checkEq("Compare", 32'h0001_0000, rd);
    apbRead(5'd3, rd, err);
    checkEq("pslverr_o", 32'd1, 32'(err));
endtask

task automatic testCleanFlow;
    logic [31:0] rnd;
    logic [31:0] pc;
    for (int i = 0; i < 8; i++) begin
        pc  = $random(seed);
        rnd = $random(seed);
        pc[1:0] = 2'b00;
        @(posedge clk);
        driveInstr(pc, '0, rnd[0]);
        @(negedge clk);
        expectPass(rnd[0]);
    end
    @(posedge clk);
    clearInstr();
endtask

task automatic testPriority;
    logic [31:0]  rnd;
    logic [31:0]  pc;
    logic [31:0]  rd;
    logic         err;
    exceptFlags_t flags;
    excCode_t     code;
    for (int i = 0; i < 20; i++) begin
        pc    = $random(seed);
        rnd   = $random(seed);
        flags = exceptFlags_t'(rnd[6:0]);
        flags.eret = 1'b0;
        // every other pc is word aligned
        if (i[0] == 1'b0) pc[1:0] = 2'b00;
        // at least one cause per instruction
        if (pc[1:0] == 2'b00 && flags == '0) flags.overflow = 1'b1;
        code = expectedCode(pc, flags);
        // EXL back to zero so each trap has to set it again
        apbWrite(REG_STATUS, 32'd0);
        @(posedge clk);
        driveInstr(pc, flags, 1'b1);
        @(negedge clk);
        expectTrap(code);
        // SETTLE cycle, this one must not trap
        @(posedge clk);
        driveInstr(pc ^ 32'h0000_0100, flags, 1'b1);
        @(negedge clk);
        expectPass(1'b1);
        @(posedge clk);
        clearInstr();
        apbRead(REG_STATUS, rd, err);
        checkEq("Status.EXL", 32'd1, 32'(rd[STATUS_EXL]));
        apbRead(REG_CAUSE, rd, err);
        checkEq("Cause.ExcCode", 32'(code), 32'(rd[CAUSE_EXC_HI:CAUSE_EXC_LO]));
        apbRead(REG_EPC, rd, err);
        checkEq("EPC", pc, rd);
    end
endtask

task automatic testEret;
    logic [31:0]  rd;
    logic         err;
    exceptFlags_t flags;
    flags      = '0;
    flags.eret = 1'b1;
    apbWrite(REG_EPC, 32'h8000_0400);
    @(posedge clk);
    driveInstr(32'h8000_0010, flags, 1'b1);
    @(negedge clk);
    expectEret(32'h8000_0400);
    @(posedge clk);
    clearInstr();
    apbRead(REG_STATUS, rd, err);
    checkEq("Status.EXL", 32'd0, 32'(rd[STATUS_EXL]));
    // epc written in the eret cycle itself
    apbSetup(REG_EPC, 1'b1, 32'h8000_0880);
    @(posedge clk);
    penable_i <= 1'b1;
    driveInstr(32'h8000_0020, flags, 1'b1);
    @(negedge clk);
    expectEret(32'h8000_0880);
    @(posedge clk);
    apbIdle();
    clearInstr();
    apbRead(REG_EPC, rd, err);
    checkEq("EPC", 32'h8000_0880, rd);
endtask

task automatic testInterrupt;
    logic [31:0] rd;
    logic        err;
    // line 0 lands on IP2, enabled by IM2 and IE
    hwInt_i <= 5'b00001;
    apbWrite(REG_STATUS, 32'h0000_0401);
    @(posedge clk);
    driveInstr(32'h8000_0100, '0, 1'b1);
    @(negedge clk);
    expectTrap(EXC_INT);
    @(posedge clk);
    clearInstr();
    // back in IDLE with EXL set
    @(posedge clk);
    driveInstr(32'h8000_0104, '0, 1'b1);
    @(negedge clk);
    expectPass(1'b1);
    @(posedge clk);
    clearInstr();
    apbWrite(REG_STATUS, 32'd0);
    // enable arrives in the same access cycle
    apbSetup(REG_STATUS, 1'b1, 32'h0000_0401);
    @(posedge clk);
    penable_i <= 1'b1;
    driveInstr(32'h8000_0108, '0, 1'b1);
    @(negedge clk);
    expectTrap(EXC_INT);
    @(posedge clk);
    apbIdle();
    clearInstr();
    // trap sets EXL over the software value
    apbRead(REG_STATUS, rd, err);
    checkEq("Status", 32'h0000_0403, rd);
    hwInt_i <= 5'b00000;
    apbWrite(REG_STATUS, 32'd0);
endtask

task automatic testTimer;
    logic [31:0] rd;
    logic [31:0] count;
    logic        err;
    int          waited;
    int          limit;
    limit  = TICK_DIV * TIMER_GAP + 8;
    waited = 0;
    rd     = '0;
    apbRead(REG_COUNT, count, err);
    apbWrite(REG_COMPARE, count + TIMER_GAP);
    // each poll costs three cycles
    while (!rd[CAUSE_TI] && waited <= limit) begin
        apbRead(REG_CAUSE, rd, err);
        waited += 3;
    end
    assert (rd[CAUSE_TI]) else begin
        errCount++;
        $display("ERROR: timer interrupt did not rise within %0d cycles", limit);
    end
    // new compare acknowledges it
    apbRead(REG_COUNT, count, err);
    apbWrite(REG_COMPARE, count + 32'd1000);
    apbRead(REG_CAUSE, rd, err);
    checkEq("Cause.IP7", 32'd0, 32'(rd[CAUSE_TI]));
endtask

//--- tbCp0Top.sv
//**************************************************
// testbench for the exception and cp0 unit
// clock, reset, DUT, run limit, test sequence
// and the closing report
//**************************************************

module tbCp0Top;

    import cp0Pkg::*;

    localparam logic [31:0] EXC_VECTOR = 32'hBFC00380;
    localparam int          TICK_DIV   = 2;
    // compare is set this many counts ahead
    localparam int          TIMER_GAP  = 16;

    // rough cycle cost of each test
    localparam int RESET_CYCLES = 16;
    localparam int REG_CYCLES   = 60;
    localparam int CLEAN_CYCLES = 30;
    localparam int PRIO_CYCLES  = 320;
    localparam int ERET_CYCLES  = 30;
    localparam int INT_CYCLES   = 50;
    localparam int TIMER_CYCLES = 40 + TICK_DIV * TIMER_GAP;
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + REG_CYCLES + CLEAN_CYCLES +
                                       PRIO_CYCLES + ERET_CYCLES + INT_CYCLES +
                                       TIMER_CYCLES);

    logic         clk;
    logic         rst_i;
    // apb master side
    logic         psel_i;
    logic         penable_i;
    logic         pwrite_i;
    regIdx_t      paddr_i;
    logic [31:0]  pwdata_i;
    logic [31:0]  prdata_o;
    logic         pready_o;
    logic         pslverr_o;
    // interrupts and memory-stage instruction
    logic [4:0]   hwInt_i;
    logic         memValid_i;
    logic [31:0]  memPc_i;
    exceptFlags_t memFlags_i;
    logic         memRegWr_i;
    // pipeline control
    logic         regWr_o;
    logic         flush_o;
    npcSel_t      npcSel_o;
    logic [31:0]  npc_o;
    excCode_t     excCode_o;

    integer       seed;
    int           errCount;
    int           cycleCount = 0;

    cp0Top #(
        .EXC_VECTOR(EXC_VECTOR),
        .TICK_DIV(TICK_DIV)
    ) cp0Top_inst (
        .clk(clk), .rst_i(rst_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .hwInt_i(hwInt_i), .memValid_i(memValid_i), .memPc_i(memPc_i),
        .memFlags_i(memFlags_i), .memRegWr_i(memRegWr_i),
        .regWr_o(regWr_o), .flush_o(flush_o), .npcSel_o(npcSel_o),
        .npc_o(npc_o), .excCode_o(excCode_o)
    );

    `include "tbCp0Tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //**************************************************
    // run limit
    //**************************************************
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d", errCount + 1);
            $display("Verification failed");
            $finish;
        end
    end

    //**************************************************
    // test sequence
    //**************************************************
    initial begin
        seed       = 32'h61d5;
        errCount   = 0;
        rst_i      <= 1'b1;
        psel_i     <= 1'b0;
        penable_i  <= 1'b0;
        pwrite_i   <= 1'b0;
        paddr_i    <= '0;
        pwdata_i   <= '0;
        hwInt_i    <= '0;
        memPc_i    <= '0;
        clearInstr();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;

        testRegAccess();
        testCleanFlow();
        testPriority();
        testEret();
        testInterrupt();
        testTimer();

        repeat (2) @(posedge clk);
        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
